//--- Makefile
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
TOP       ?= tbSingleCycleMips
FILELIST  ?= singleCycleMips.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tbSingleCycleMips.sv
//==========================================================
// single-cycle MIPS testbench
// ROM and RAM models, directed tests checked via stores
// and the fetch address
//==========================================================

`timescale 1ns/1ps

module tbSingleCycleMips;

    // tests take about 330 cycles including resets
    localparam int          TIMEOUT_CYCLES = 2000;
    // opcode 6'h3f decodes to nothing
    localparam logic [31:0] NOP_WORD       = 32'hfc00_0000;

    logic                            Clk;
    logic                            reset;
    mipsPkg::wordT                   instr;
    mipsPkg::wordT                   instrAddr;
    mipsPkg::wordT                   memReadData;
    logic [mipsPkg::DMEM_ADDR_W-1:0] memAddr;
    mipsPkg::wordT                   memWriteData;
    logic                            memWriteEn;

    logic [31:0] rom [256];
    logic [31:0] ram [128];
    logic [31:0] lfsrState;
    int          progLen;
    int          errorCount;
    int          testCount;
    int          testErrorsAtStart;
    int          cycleCount = 0;

    // observed and expected stores plus the fetch trace
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    logic [31:0] pcTrace [$];

    singleCycleMips dut (
        .Clk          (Clk),
        .reset        (reset),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWriteEn   (memWriteEn)
    );

    //==========================================================
    // clock, memories, timeout
    //==========================================================

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // both memories answer within the cycle
    assign instr       = rom[instrAddr[9:2]];
    assign memReadData = ram[memAddr];

    always @(posedge Clk) begin
        if (reset && memWriteEn) begin
            ram[memAddr] = memWriteData;
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //==========================================================
    // helpers
    //==========================================================

    function automatic logic [31:0] rType(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
        return {6'b000000, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrStep();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsrStep()};
        end
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        rom[progLen[7:0]] = word;
        progLen++;
    endtask

    task automatic ramWrite(input int wordIdx, input logic [31:0] value);
        ram[wordIdx[6:0]] = value;
    endtask

    // byte address as the ALU sees it, queued as the word address
    task automatic expectStore(input logic [31:0] byteAddr, input logic [31:0] data);
        expAddrQ.push_back((byteAddr >> 2) & 32'h0000_007f);
        expDataQ.push_back(data);
    endtask

    // reset held from here until releaseReset
    task automatic beginTest();
        @(posedge Clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = NOP_WORD;
        end
        for (int i = 0; i < 128; i++) begin
            ram[i[6:0]] = 32'hdead_0000 | 32'(i);
        end
        progLen = 0;
        storeAddrQ.delete();
        storeDataQ.delete();
        expAddrQ.delete();
        expDataQ.delete();
        pcTrace.delete();
        testErrorsAtStart = errorCount;
    endtask

    task automatic releaseReset();
        repeat (5) @(posedge Clk);
        #1;
        reset = 1'b1;
    endtask

    // sample mid-cycle until the fetch reaches endAddr
    task automatic runProgram(input logic [31:0] endAddr);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge Clk);
            pcTrace.push_back(instrAddr);
            if (memWriteEn) begin
                storeAddrQ.push_back(32'(memAddr));
                storeDataQ.push_back(memWriteData);
            end
            if (instrAddr == endAddr) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic compareStores();
        checkValue("store count", storeAddrQ.size(), expAddrQ.size());
        for (int i = 0; i < storeAddrQ.size() && i < expAddrQ.size(); i++) begin
            checkValue("memAddr", storeAddrQ[i], expAddrQ[i]);
            checkValue("memWriteData", storeDataQ[i], expDataQ[i]);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == testErrorsAtStart) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errorCount - testErrorsAtStart);
        end
    endtask

    //==========================================================
    // directed tests
    //==========================================================

    task automatic testReset();
        beginTest();
        releaseReset();
        for (int i = 0; i < 10; i++) begin
            @(negedge Clk);
            checkValue("instrAddr", instrAddr, 32'(i * 4));
            checkValue("memWriteEn", 32'(memWriteEn), 32'd0);
        end
        finishTest("reset state");
    endtask

    task automatic testRType();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        a    = 32'hffff_fff6;
        b    = 32'h0000_0007;
        base = 32'h0000_0040;
        beginTest();
        ramWrite(0, a);
        ramWrite(1, b);
        ramWrite(2, base);
        emit(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd2, 16'd4));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd9, 16'd8));
        emit(rType(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd3));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd3, 16'd0));
        emit(rType(mipsPkg::fnSub, 5'd1, 5'd2, 5'd4));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd4, 16'd4));
        emit(rType(mipsPkg::fnAnd, 5'd1, 5'd2, 5'd5));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd5, 16'd8));
        emit(rType(mipsPkg::fnOr, 5'd1, 5'd2, 5'd6));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd6, 16'd12));
        // -10 < 7 holds only as a signed compare
        emit(rType(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd7));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd7, 16'd16));
        emit(rType(mipsPkg::fnSlt, 5'd2, 5'd1, 5'd8));
        emit(iType(mipsPkg::opSw, 5'd9, 5'd8, 16'd20));
        expectStore(base, a + b);
        expectStore(base + 32'd4, a - b);
        expectStore(base + 32'd8, a & b);
        expectStore(base + 32'd12, a | b);
        expectStore(base + 32'd16, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectStore(base + 32'd20, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        releaseReset();
        runProgram(32'(progLen * 4));
        compareStores();
        finishTest("r-type arithmetic");
    endtask

    task automatic testRegZero();
        beginTest();
        ramWrite(0, 32'h1234_5678);
        ramWrite(1, 32'h0000_1111);
        emit(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd2, 16'd4));
        emit(rType(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd0));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd0, 16'd8));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd0, 16'd0));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd0, 16'd12));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd3, 16'd0));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd3, 16'd16));
        expectStore(32'd8, 32'd0);
        expectStore(32'd12, 32'd0);
        expectStore(32'd16, 32'h1234_5678);
        releaseReset();
        runProgram(32'(progLen * 4));
        compareStores();
        finishTest("register zero");
    endtask

    task automatic testBranch();
        beginTest();
        ramWrite(0, 32'd5);
        ramWrite(1, 32'd5);
        ramWrite(2, 32'd6);
        emit(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd2, 16'd4));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd3, 16'd8));
        // taken branch skips three stores
        emit(iType(mipsPkg::opBeq, 5'd1, 5'd2, 16'd3));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd32));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd36));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd40));
        // 5 vs 6 falls through
        emit(iType(mipsPkg::opBeq, 5'd1, 5'd3, 16'd1));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd3, 16'd44));
        expectStore(32'd44, 32'd6);
        releaseReset();
        runProgram(32'(progLen * 4));
        checkValue("instrAddr after taken beq", pcTrace[4], 32'd12 + 32'd4 + (32'd3 << 2));
        checkValue("instrAddr after untaken beq", pcTrace[5], 32'd28 + 32'd4);
        compareStores();
        finishTest("branches");
    endtask

    task automatic testJump();
        beginTest();
        ramWrite(0, 32'h0000_0055);
        emit(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'd0));
        emit({mipsPkg::opJ, 26'd4});
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd4));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd8));
        emit(iType(mipsPkg::opSw, 5'd0, 5'd1, 16'd12));
        expectStore(32'd12, 32'h0000_0055);
        releaseReset();
        runProgram(32'(progLen * 4));
        // top nibble of pc + 4 then the index in bytes
        checkValue("instrAddr after j", pcTrace[2], (32'd8 & 32'hf000_0000) | (32'd4 << 2));
        compareStores();
        finishTest("jump");
    endtask

    task automatic testRandom();
        logic [31:0] a;
        logic [31:0] b;
        beginTest();
        // strides and loop bounds live at the top of RAM
        ramWrite(124, 32'd8);
        ramWrite(125, 32'd12);
        ramWrite(126, 32'd160);
        ramWrite(127, 32'd256);
        for (int i = 0; i < 20; i++) begin
            a = randomWord();
            b = randomWord();
            ramWrite(2 * i, a);
            ramWrite(2 * i + 1, b);
            expectStore(32'(256 + 12 * i), a + b);
            expectStore(32'(260 + 12 * i), a - b);
            expectStore(32'(264 + 12 * i), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        end
        emit(iType(mipsPkg::opLw, 5'd0, 5'd10, 16'd496));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd11, 16'd500));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd12, 16'd504));
        emit(iType(mipsPkg::opLw, 5'd0, 5'd14, 16'd508));
        emit(rType(mipsPkg::fnAdd, 5'd0, 5'd0, 5'd13));
        // loop body starts at word 5
        emit(iType(mipsPkg::opLw, 5'd13, 5'd1, 16'd0));
        emit(iType(mipsPkg::opLw, 5'd13, 5'd2, 16'd4));
        emit(rType(mipsPkg::fnAdd, 5'd1, 5'd2, 5'd3));
        emit(iType(mipsPkg::opSw, 5'd14, 5'd3, 16'd0));
        emit(rType(mipsPkg::fnSub, 5'd1, 5'd2, 5'd4));
        emit(iType(mipsPkg::opSw, 5'd14, 5'd4, 16'd4));
        emit(rType(mipsPkg::fnSlt, 5'd1, 5'd2, 5'd5));
        emit(iType(mipsPkg::opSw, 5'd14, 5'd5, 16'd8));
        emit(rType(mipsPkg::fnAdd, 5'd13, 5'd10, 5'd13));
        emit(rType(mipsPkg::fnAdd, 5'd14, 5'd11, 5'd14));
        emit(iType(mipsPkg::opBeq, 5'd13, 5'd12, 16'd1));
        emit({mipsPkg::opJ, 26'd5});
        releaseReset();
        runProgram(32'(progLen * 4));
        compareStores();
        finishTest("random operands");
    endtask

    //==========================================================
    // main sequence
    //==========================================================

    initial begin
        reset      = 1'b0;
        errorCount = 0;
        testCount  = 0;
        progLen    = 0;
        lfsrState  = 32'h7bbe_708a;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = NOP_WORD;
        end
        for (int i = 0; i < 128; i++) begin
            ram[i[6:0]] = 32'hdead_0000 | 32'(i);
        end
        testReset();
        testRType();
        testRegZero();
        testBranch();
        testJump();
        testRandom();
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/alu.sv
//==========================================================
// 32-bit ALU
// add, sub, and, or, signed slt, plus zero flag
//==========================================================

`timescale 1ns/1ps

module alu (
    input  mipsPkg::aluOpE aluOp,
    input  mipsPkg::wordT  operandA,
    input  mipsPkg::wordT  operandB,
    output mipsPkg::wordT  result,
    output logic           zero
);

    // signed compare for slt
    logic lessThan;

    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            mipsPkg::aluAdd: result = operandA + operandB;
            mipsPkg::aluSub: result = operandA - operandB;
            mipsPkg::aluAnd: result = operandA & operandB;
            mipsPkg::aluOr:  result = operandA | operandB;
            // one or zero in the low bit
            mipsPkg::aluSlt: result = {{(mipsPkg::DATA_W-1){1'b0}}, lessThan};
            default:         result = operandA + operandB;
        endcase
    end

    // beq takes its decision from this
    assign zero = (result == '0);

endmodule

//--- hdl/aluDecoder.sv
//==========================================================
// ALU decoder
// operation class plus function field to one ALU operation
//==========================================================

`timescale 1ns/1ps

module aluDecoder (
    input  mipsPkg::aluClassE aluClass,
    input  mipsPkg::functE    funct,
    output mipsPkg::aluOpE    aluOp
);

    always_comb begin
        case (aluClass)
            // lw / sw address
            mipsPkg::classAdd: aluOp = mipsPkg::aluAdd;
            // beq compare
            mipsPkg::classSub: aluOp = mipsPkg::aluSub;
            mipsPkg::classFunct: begin
                case (funct)
                    mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
                    // unsupported funct behaves as add
                    default:        aluOp = mipsPkg::aluAdd;
                endcase
            end
            default: aluOp = mipsPkg::aluAdd;
        endcase
    end

endmodule

//--- hdl/mainDecoder.sv
//==========================================================
// main decoder
// opcode to datapath control signals and ALU class
//==========================================================

`timescale 1ns/1ps

module mainDecoder (
    input  mipsPkg::opcodeE   opcode,
    output logic              regDst,
    output logic              aluSrc,
    output logic              memToReg,
    output logic              regWrite,
    output logic              memWrite,
    output logic              branch,
    output logic              jump,
    output mipsPkg::aluClassE aluClass
);

    always_comb begin
        // unknown opcodes fall through as a no-op
        regDst   = 1'b0;
        aluSrc   = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        aluClass = mipsPkg::classAdd;

        case (opcode)
            mipsPkg::opRType: begin
                // rd <= rs op rt
                regDst   = 1'b1;
                regWrite = 1'b1;
                aluClass = mipsPkg::classFunct;
            end
            mipsPkg::opLw: begin
                // address is rs + imm
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::opSw: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                // subtract for the zero compare
                branch   = 1'b1;
                aluClass = mipsPkg::classSub;
            end
            mipsPkg::opJ: begin
                jump = 1'b1;
            end
            default: begin
            end
        endcase

        // a store never writes back to the register file
        assert (!(memWrite && regWrite));
    end

endmodule

//--- hdl/mipsPkg.sv
//==========================================================
// MIPS core package
// word and register widths, reset vector, and the opcode,
// function and ALU operation encodings
//==========================================================

package mipsPkg;

    // datapath widths
    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int REG_COUNT   = 32;
    // word address into the data memory
    localparam int DMEM_ADDR_W = 7;

    // first fetch after reset
    localparam logic [DATA_W-1:0] RESET_PC = '0;

    typedef logic [DATA_W-1:0]     wordT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opBeq   = 6'b000100,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeE;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functE;

    // operation class from the main decoder
    typedef enum logic [1:0] {
        classAdd   = 2'b00,
        classSub   = 2'b01,
        classFunct = 2'b10
    } aluClassE;

    // ALU operation select
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b100
    } aluOpE;

endpackage

//--- hdl/pcUnit.sv
//==========================================================
// program counter
// holds pc, picks sequential, branch or jump next address
//==========================================================

`timescale 1ns/1ps

module pcUnit (
    input  logic          Clk,
    input  logic          reset,
    input  logic          branch,
    input  logic          jump,
    input  logic          zero,
    input  logic [15:0]   immediate,
    input  logic [25:0]   jumpIndex,
    output mipsPkg::wordT pc
);

    mipsPkg::wordT pcPlus4;
    mipsPkg::wordT branchOffset;
    mipsPkg::wordT branchTarget;
    mipsPkg::wordT jumpTarget;
    mipsPkg::wordT nextPc;

    assign pcPlus4 = pc + 32'd4;

    // sign-extended word offset, shifted to bytes
    assign branchOffset = {{(mipsPkg::DATA_W-18){immediate[15]}}, immediate, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // pseudo-direct, top nibble from pc + 4
    assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

    // jump wins over a taken branch
    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branch && zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            pc <= mipsPkg::RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // fetch address stays word aligned
    pcAligned : assert property (
        @(posedge Clk) disable iff (!reset) pc[1:0] == 2'b00
    );

endmodule

//--- hdl/registerFile.sv
//==========================================================
// register file
// 32 x 32-bit, two async read ports, one write port,
// register zero hardwired to zero
//==========================================================

`timescale 1ns/1ps

module registerFile (
    input  logic             Clk,
    input  logic             reset,
    input  logic             writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    output mipsPkg::wordT    readDataA,
    output mipsPkg::wordT    readDataB
);

    mipsPkg::wordT regs [mipsPkg::REG_COUNT];

    // write at the edge ending the instruction
    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < mipsPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // $zero never takes a write
            if (writeEn && (writeAddr != '0)) begin
                regs[writeAddr] <= writeData;
            end
        end
    end

    // combinational reads, same cycle as decode
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    //==========================================================
    // checks
    //==========================================================

    // $zero stays zero across any write history
    zeroReadA : assert property (
        @(posedge Clk) disable iff (!reset)
        (readAddrA == '0) |-> (readDataA == '0)
    );

    zeroReadB : assert property (
        @(posedge Clk) disable iff (!reset)
        (readAddrB == '0) |-> (readDataB == '0)
    );

endmodule

//--- hdl/singleCycleMips.sv
//==========================================================
// single-cycle MIPS core
// one instruction per clock: add sub and or slt lw sw beq j
//==========================================================

`timescale 1ns/1ps

module singleCycleMips (
    input  logic                            Clk,
    input  logic                            reset,
    // instruction fetch
    input  mipsPkg::wordT                   instr,
    output mipsPkg::wordT                   instrAddr,
    // data memory
    input  mipsPkg::wordT                   memReadData,
    output logic [mipsPkg::DMEM_ADDR_W-1:0] memAddr,
    output mipsPkg::wordT                   memWriteData,
    output logic                            memWriteEn
);

    //==========================================================
    // instruction fields
    //==========================================================

    mipsPkg::opcodeE  opcode;
    mipsPkg::functE   funct;
    mipsPkg::regAddrT rs;
    mipsPkg::regAddrT rt;
    mipsPkg::regAddrT rd;
    logic [15:0]      immediate;
    logic [25:0]      jumpIndex;
    mipsPkg::wordT    signExtImm;

    assign opcode    = mipsPkg::opcodeE'(instr[31:26]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign immediate = instr[15:0];
    assign funct     = mipsPkg::functE'(instr[5:0]);
    assign jumpIndex = instr[25:0];

    assign signExtImm = {{(mipsPkg::DATA_W-16){immediate[15]}}, immediate};

    // controls
    logic              regDst;
    logic              aluSrc;
    logic              memToReg;
    logic              regWrite;
    logic              memWrite;
    logic              branch;
    logic              jump;
    mipsPkg::aluClassE aluClass;
    mipsPkg::aluOpE    aluOp;

    // datapath
    mipsPkg::regAddrT writeReg;
    mipsPkg::wordT    readDataA;
    mipsPkg::wordT    readDataB;
    mipsPkg::wordT    aluOperandB;
    mipsPkg::wordT    aluResult;
    logic             zero;
    mipsPkg::wordT    writeBack;

    //==========================================================
    // decode
    //==========================================================

    mainDecoder uMainDecoder (
        .opcode   (opcode),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .memToReg (memToReg),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .branch   (branch),
        .jump     (jump),
        .aluClass (aluClass)
    );

    aluDecoder uAluDecoder (
        .aluClass (aluClass),
        .funct    (funct),
        .aluOp    (aluOp)
    );

    //==========================================================
    // execute and write back
    //==========================================================

    // rd for R-type, rt for lw
    assign writeReg = regDst ? rd : rt;

    registerFile uRegisterFile (
        .Clk       (Clk),
        .reset     (reset),
        .writeEn   (regWrite),
        .writeAddr (writeReg),
        .writeData (writeBack),
        .readAddrA (rs),
        .readAddrB (rt),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    // immediate for lw / sw
    assign aluOperandB = aluSrc ? signExtImm : readDataB;

    alu uAlu (
        .aluOp    (aluOp),
        .operandA (readDataA),
        .operandB (aluOperandB),
        .result   (aluResult),
        .zero     (zero)
    );

    assign writeBack = memToReg ? memReadData : aluResult;

    // byte address to word address
    assign memAddr      = aluResult[mipsPkg::DMEM_ADDR_W+1:2];
    assign memWriteData = readDataB;
    assign memWriteEn   = memWrite;

    pcUnit uPcUnit (
        .Clk       (Clk),
        .reset     (reset),
        .branch    (branch),
        .jump      (jump),
        .zero      (zero),
        .immediate (immediate),
        .jumpIndex (jumpIndex),
        .pc        (instrAddr)
    );

endmodule

//--- singleCycleMips.f
hdl/mipsPkg.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/pcUnit.sv
hdl/singleCycleMips.sv
dv/tbSingleCycleMips.sv
